//--- compile.f
source/out_pkg.sv
source/beat_if.sv
source/requantizer.sv
source/ram_output.sv
source/out_ram_switch.sv
source/apb_readout.sv
source/out_path_top.sv
verification/tb_out_path.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_out_path
FILELIST   := compile.f
SIM_FLAGS  := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Finished with no errors

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/tb_out_path.sv
`timescale 1ns/100ps
`default_nettype none

module tb_out_path;

  localparam int ROWS          = 4;
  localparam int COLS          = 16;
  localparam int RAM_LATENCY   = 2;
  localparam int FRAME_ELEMS   = ROWS * COLS;
  localparam int NUM_FRAMES    = 9;  // frames sent over the whole run
  localparam int MAX_GAP       = 3;
  localparam int POLL_LIMIT    = 2000;
  // window reads dominate with setup, waits and an idle cycle for each
  localparam int CYC_PER_BEAT  = ROWS * (RAM_LATENCY + 4) + ROWS + MAX_GAP + 8;
  localparam int TIMEOUT_NS    = (NUM_FRAMES * COLS * CYC_PER_BEAT + 2000) * 10;
  localparam out_pkg::apb_addr_t WIN_BASE = 12'h800;

  logic                     clk;
  logic                     rstn;
  logic                     acc_valid;
  out_pkg::acc_t [ROWS-1:0] acc_data;
  logic                     acc_last;
  logic                     acc_ready;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  out_pkg::apb_addr_t       paddr;
  out_pkg::apb_data_t       pwdata;
  out_pkg::apb_data_t       prdata;
  logic                     pready;
  logic                     pslverr;

  logic [31:0]     lcg_state = 32'hfe1b_d000;
  out_pkg::acc_t   frame_acc [COLS][ROWS];  // lanes of the frame being sent
  out_pkg::y_t     exp_q [$];               // expected elements in readout order
  out_pkg::shift_t cur_shift = '0;
  int              apb_waits = 0;
  int              errors = 0;
  int              tests_run = 0;
  int              tests_failed = 0;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  out_path_top #(
    .ROWS        (ROWS),
    .COLS        (COLS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_out_path_top (
    .clk         (clk),
    .rstn        (rstn),
    .i_acc_valid (acc_valid),
    .i_acc_data  (acc_data),
    .i_acc_last  (acc_last),
    .o_acc_ready (acc_ready),
    .i_psel      (psel),
    .i_penable   (penable),
    .i_pwrite    (pwrite),
    .i_paddr     (paddr),
    .i_pwdata    (pwdata),
    .o_prdata    (prdata),
    .o_pready    (pready),
    .o_pslverr   (pslverr)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // expected element is the lane shifted right arithmetically and clipped to -128..127
  function automatic out_pkg::y_t model_elem(input out_pkg::acc_t acc, input int sh);
    longint v;
    v = longint'(acc) >>> sh;
    if (v > 127) v = 127;
    else if (v < -128) v = -128;
    return out_pkg::y_t'(v);
  endfunction

  function automatic out_pkg::acc_t sat_value(input int k);
    case (k % 10)
      0:       return 32'sh7fff_ffff;
      1:       return 32'sh8000_0000;
      2:       return 32'sd2047;   // 127 at shift 4
      3:       return 32'sd2048;   // one past the top at shift 4
      4:       return -32'sd2048;
      5:       return -32'sd2049;  // floors to -129 and clips
      6:       return 32'sd127;
      7:       return -32'sd128;
      8:       return 32'sd300;
      default: return -32'sd77;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("** Failure at %0t ns: %s", $time, msg);
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - err_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // one APB transfer that counts its wait states in apb_waits
  task automatic apb_xfer(input logic wr, input out_pkg::apb_addr_t addr,
                          input out_pkg::apb_data_t wdata, output out_pkg::apb_data_t rdata);
    @(posedge clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable   = 1'b1;
    apb_waits = 0;
    @(negedge clk);
    while (!pready) begin
      apb_waits++;
      @(negedge clk);
    end
    rdata = prdata;
    if (pslverr !== 1'b0) report_mismatch("o_pslverr", 32'(pslverr), 32'd0);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input out_pkg::apb_addr_t addr, input out_pkg::apb_data_t data);
    out_pkg::apb_data_t unused;
    apb_xfer(1'b1, addr, data, unused);
  endtask

  task automatic apb_read(input out_pkg::apb_addr_t addr, output out_pkg::apb_data_t data);
    apb_xfer(1'b0, addr, 32'd0, data);
  endtask

  task automatic set_shift(input out_pkg::shift_t s);
    apb_write(out_pkg::REG_SHIFT, out_pkg::apb_data_t'(s));
    cur_shift = s;
  endtask

  // random lanes sign extended from the low bits of the lcg
  task automatic fill_random(input int bits);
    logic [31:0] v;
    for (int b = 0; b < COLS; b++) begin
      for (int r = 0; r < ROWS; r++) begin
        v = lcg_next() << (32 - bits);
        frame_acc[b][r] = out_pkg::acc_t'(v) >>> (32 - bits);
      end
    end
  endtask

  task automatic send_frame(input int max_gap);
    int gap;
    @(posedge clk);
    #1;
    for (int b = 0; b < COLS; b++) begin
      gap = (max_gap > 0) ? int'(lcg_next() % (max_gap + 1)) : 0;
      acc_valid = 1'b0;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      acc_valid = 1'b1;
      acc_last  = (b == COLS - 1);
      for (int r = 0; r < ROWS; r++) begin
        acc_data[r] = frame_acc[b][r];
        exp_q.push_back(model_elem(frame_acc[b][r], int'(cur_shift)));  // index b*ROWS+r
      end
      @(negedge clk);
      while (!acc_ready) @(negedge clk);
      @(posedge clk);
      #1;
    end
    acc_valid = 1'b0;
    acc_last  = 1'b0;
  endtask

  task automatic read_frame();
    out_pkg::apb_data_t data;
    out_pkg::y_t        exp;
    logic [31:0]        exp32;
    int                 polls;
    polls = 0;
    data  = '0;
    while (data[0] !== 1'b1 && polls < POLL_LIMIT) begin
      apb_read(out_pkg::REG_STATUS, data);
      polls++;
    end
    if (data[0] !== 1'b1) begin
      report_failure("frame_ready never came up while polling STATUS");
      return;
    end
    for (int i = 0; i < FRAME_ELEMS; i++) begin
      apb_read(WIN_BASE | out_pkg::apb_addr_t'(i << 2), data);
      if (apb_waits != RAM_LATENCY) report_mismatch("window wait cycles", apb_waits, RAM_LATENCY);
      if (exp_q.size() == 0) begin
        report_failure("window holds an element that was never sent");
      end else begin
        exp   = exp_q.pop_front();
        exp32 = {{24{exp[7]}}, exp};
        if (data !== exp32) report_mismatch($sformatf("o_prdata[%0d]", i), data, exp32);
      end
    end
    apb_write(out_pkg::REG_CONTROL, 32'h1);  // release the bank
    apb_write(out_pkg::REG_CONTROL, 32'h0);
  endtask

  task automatic test_reset();
    out_pkg::apb_data_t data;
    int                 err0;
    err0 = errors;
    rstn = 1'b0;
    repeat (8) begin
      @(posedge clk);
      #1;
      if (acc_ready !== 1'b0) report_mismatch("o_acc_ready", 32'(acc_ready), 32'd0);
      if (pready !== 1'b0) report_mismatch("o_pready", 32'(pready), 32'd0);
    end
    rstn = 1'b1;
    apb_read(out_pkg::REG_STATUS, data);
    if (data !== 32'd0) report_mismatch("STATUS", data, 32'd0);
    apb_read(out_pkg::REG_SHIFT, data);
    if (data !== 32'd0) report_mismatch("SHIFT", data, 32'd0);
    report_test("reset", err0);
  endtask

  task automatic test_shift_reg();
    out_pkg::apb_data_t data;
    int                 err0;
    err0 = errors;
    apb_write(out_pkg::REG_SHIFT, 32'h13);
    if (apb_waits != 0) report_mismatch("SHIFT write wait cycles", apb_waits, 32'd0);
    apb_read(out_pkg::REG_SHIFT, data);
    if (apb_waits != 0) report_mismatch("SHIFT read wait cycles", apb_waits, 32'd0);
    if (data !== 32'h13) report_mismatch("SHIFT", data, 32'h13);
    apb_read(out_pkg::REG_STATUS, data);
    if (apb_waits != 0) report_mismatch("STATUS read wait cycles", apb_waits, 32'd0);
    set_shift(5'd0);
    report_test("shift_register", err0);
  endtask

  task automatic test_single_frame();
    out_pkg::apb_data_t data;
    int                 err0;
    err0 = errors;
    set_shift(5'd0);
    fill_random(10);
    send_frame(0);
    read_frame();
    apb_read(out_pkg::REG_STATUS, data);
    if (data !== 32'd0) report_mismatch("STATUS after release", data, 32'd0);
    if (exp_q.size() != 0) report_failure("elements left over after the frame");
    report_test("single_frame", err0);
  endtask

  task automatic test_saturation();
    int err0;
    err0 = errors;
    for (int b = 0; b < COLS; b++) begin
      for (int r = 0; r < ROWS; r++) frame_acc[b][r] = sat_value(b * ROWS + r);
    end
    set_shift(5'd4);
    send_frame(0);
    read_frame();
    set_shift(5'd0);
    send_frame(0);
    read_frame();
    report_test("saturation_shift", err0);
  endtask

  task automatic test_ping_pong();
    logic rose;
    int   err0;
    err0 = errors;
    rose = 1'b0;
    set_shift(5'd1);
    fill_random(9);
    send_frame(0);
    fill_random(9);
    send_frame(0);
    fill_random(9);
    fork
      send_frame(0);
      begin
        repeat (12) @(negedge clk);  // third frame's first beat parks in the requantizer
        repeat (40) begin
          @(negedge clk);
          if (acc_ready !== 1'b0 && !rose) begin
            rose = 1'b1;
            report_mismatch("o_acc_ready", 32'(acc_ready), 32'd0);
          end
        end
        read_frame();
      end
    join
    read_frame();
    read_frame();
    if (exp_q.size() != 0) report_failure("elements left over after ping-pong frames");
    report_test("ping_pong", err0);
  endtask

  task automatic test_stream();
    out_pkg::apb_data_t data;
    int                 err0;
    err0 = errors;
    set_shift(5'd3);
    fork
      begin
        repeat (3) begin
          fill_random(13);
          send_frame(MAX_GAP);
        end
      end
      repeat (3) read_frame();
    join
    if (exp_q.size() != 0) report_failure("stream left elements that were never read");
    apb_read(out_pkg::REG_STATUS, data);
    if (data !== 32'd0) report_mismatch("STATUS after stream", data, 32'd0);
    report_test("stream", err0);
  endtask

  initial begin
    rstn      = 1'b0;
    acc_valid = 1'b0;
    acc_data  = '0;
    acc_last  = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    test_reset();
    test_shift_reg();
    test_single_frame();
    test_saturation();
    test_ping_pong();
    test_stream();
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the run is stuck", TIMEOUT_NS);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- source/out_path_top.sv
`timescale 1ns/100ps
`default_nettype none

module out_path_top #(
  parameter int ROWS        = 4,
  parameter int COLS        = 16,
  parameter int RAM_LATENCY = 2
) (
  input  logic                     clk,
  input  logic                     rstn,
  // accumulator stream
  input  logic                     i_acc_valid,
  input  out_pkg::acc_t [ROWS-1:0] i_acc_data,
  input  logic                     i_acc_last,
  output logic                     o_acc_ready,
  // apb slave
  input  logic                     i_psel,
  input  logic                     i_penable,
  input  logic                     i_pwrite,
  input  out_pkg::apb_addr_t       i_paddr,
  input  out_pkg::apb_data_t       i_pwdata,
  output out_pkg::apb_data_t       o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr
);

  out_pkg::win_idx_t rd_addr;
  out_pkg::y_t       rd_data;
  out_pkg::shift_t   shift;
  logic              done_fill;
  logic              done_firmware;

  beat_if #(.ROWS(ROWS)) u_beat ();

  requantizer #(
    .ROWS (ROWS)
  ) u_requantizer (
    .clk         (clk),
    .rstn        (rstn),
    .i_acc_valid (i_acc_valid),
    .i_acc_data  (i_acc_data),
    .i_acc_last  (i_acc_last),
    .o_acc_ready (o_acc_ready),
    .i_shift     (shift),
    .o_beat      (u_beat.src)
  );

  out_ram_switch #(
    .ROWS        (ROWS),
    .COLS        (COLS),
    .RAM_LATENCY (RAM_LATENCY)
  ) u_out_ram_switch (
    .clk             (clk),
    .rstn            (rstn),
    .i_beat          (u_beat.dst),
    .i_rd_addr       (rd_addr),
    .o_rd_data       (rd_data),
    .o_done_fill     (done_fill),
    .i_done_firmware (done_firmware)
  );

  apb_readout #(
    .RAM_LATENCY (RAM_LATENCY)
  ) u_apb_readout (
    .clk             (clk),
    .rstn            (rstn),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_pwrite        (i_pwrite),
    .i_paddr         (i_paddr),
    .i_pwdata        (i_pwdata),
    .o_prdata        (o_prdata),
    .o_pready        (o_pready),
    .o_pslverr       (o_pslverr),
    .o_rd_addr       (rd_addr),
    .i_rd_data       (rd_data),
    .i_done_fill     (done_fill),
    .o_done_firmware (done_firmware),
    .o_shift         (shift)
  );

endmodule

`default_nettype wire

//--- source/apb_readout.sv
`timescale 1ns/100ps
`default_nettype none

module apb_readout #(
  parameter int RAM_LATENCY = 2
) (
  input  logic               clk,
  input  logic               rstn,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  out_pkg::apb_addr_t i_paddr,
  input  out_pkg::apb_data_t i_pwdata,
  output out_pkg::apb_data_t o_prdata,
  output logic               o_pready,
  output logic               o_pslverr,
  output out_pkg::win_idx_t  o_rd_addr,
  input  out_pkg::y_t        i_rd_data,
  input  logic               i_done_fill,
  output logic               o_done_firmware,
  output out_pkg::shift_t    o_shift
);

  localparam int WAIT_BITS = $clog2(RAM_LATENCY + 1);

  logic                 access, is_win, wr_en, win_ready, frame_ready;
  logic [WAIT_BITS-1:0] wait_cnt;

  assign access    = i_psel && i_penable;
  assign is_win    = i_paddr[out_pkg::WIN_BIT];
  assign win_ready = wait_cnt == WAIT_BITS'(RAM_LATENCY);
  assign wr_en     = access && i_pwrite && !is_win;  // window is read only
  assign o_rd_addr = i_paddr[out_pkg::WIN_MSB:out_pkg::WIN_LSB];  // valid from setup phase
  assign o_pslverr = 1'b0;

  // window reads wait out the RAM latency, everything else is zero-wait
  assign o_pready = access && (!is_win || i_pwrite || win_ready);

  always_ff @(posedge clk) begin
    if (!rstn || !access || o_pready) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      o_done_firmware <= 1'b0;
      o_shift         <= '0;
      frame_ready     <= 1'b0;
    end else begin
      if (wr_en && i_paddr == out_pkg::REG_CONTROL) o_done_firmware <= i_pwdata[0];
      if (wr_en && i_paddr == out_pkg::REG_SHIFT)   o_shift <= i_pwdata[out_pkg::SHIFT_BITS-1:0];
      if (i_done_fill) begin
        frame_ready <= 1'b1;
      end else if (wr_en && i_paddr == out_pkg::REG_CONTROL && i_pwdata[0]) begin
        frame_ready <= 1'b0;  // firmware releases the bank
      end
    end
  end

  always_comb begin
    if (is_win) begin
      o_prdata = out_pkg::apb_data_t'(i_rd_data);  // sign extended
    end else if (i_paddr == out_pkg::REG_STATUS) begin
      o_prdata = {31'b0, frame_ready};
    end else if (i_paddr == out_pkg::REG_CONTROL) begin
      o_prdata = {31'b0, o_done_firmware};
    end else if (i_paddr == out_pkg::REG_SHIFT) begin
      o_prdata = {{(32 - out_pkg::SHIFT_BITS){1'b0}}, o_shift};
    end else begin
      o_prdata = '0;
    end
  end

endmodule

`default_nettype wire

//--- source/out_ram_switch.sv
`timescale 1ns/100ps
`default_nettype none

module out_ram_switch #(
  parameter int ROWS        = 4,
  parameter int COLS        = 16,
  parameter int RAM_LATENCY = 2
) (
  input  logic              clk,
  input  logic              rstn,
  beat_if.dst               i_beat,
  input  out_pkg::win_idx_t i_rd_addr,
  output out_pkg::y_t       o_rd_data,
  output logic              o_done_fill,
  input  logic              i_done_firmware
);

  localparam int DEPTH     = ROWS * COLS;
  localparam int ADDR_BITS = $clog2(DEPTH);
  localparam int ROW_BITS  = (ROWS > 1) ? $clog2(ROWS) : 1;

  typedef enum logic [1:0] {W_IDLE, W_WRITE, W_FILL, W_SWITCH} w_state_t;
  typedef enum logic [2:0] {R_IDLE, R_DONE_FILL, R_READ, R_WAIT, R_SWITCH} r_state_t;

  w_state_t state_w, state_w_next;
  r_state_t state_r, state_r_next;

  logic                      i_write, i_read;  // bank select, write and read side
  logic                      take, loaded, last_q, en_write, lane_last, df_was_high;
  logic [ROW_BITS-1:0]       row_cnt;
  logic [ADDR_BITS-1:0]      w_addr, r_addr;
  out_pkg::y_t [ROWS-1:0]    shift_reg;
  logic [1:0]                done_write, done_read, ram_wen;
  logic [1:0][ADDR_BITS-1:0] ram_addr;
  out_pkg::y_t [1:0]         ram_dout;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_w <= W_IDLE;
      state_r <= R_IDLE;
      i_write <= 1'b0;
      i_read  <= 1'b0;
    end else begin
      state_w <= state_w_next;
      state_r <= state_r_next;
      if (state_w == W_SWITCH) i_write <= !i_write;
      if (state_r == R_SWITCH) i_read  <= !i_read;
    end
  end

  // write side
  always_comb begin
    state_w_next = state_w;
    case (state_w)
      W_IDLE:   if (done_read[i_write]) state_w_next = W_WRITE;  // wait for a free bank
      W_WRITE:  if (en_write && lane_last && last_q) state_w_next = W_FILL;
      W_FILL:   state_w_next = W_SWITCH;
      W_SWITCH: state_w_next = W_IDLE;
      default:  state_w_next = W_IDLE;
    endcase
  end

  assign i_beat.ready = (state_w == W_WRITE) && !loaded;
  assign take         = i_beat.valid && i_beat.ready;
  assign en_write     = (state_w == W_WRITE) && loaded;  // one lane per cycle
  assign lane_last    = row_cnt == ROW_BITS'(ROWS - 1);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      loaded <= 1'b0;
    end else if (take) begin
      loaded <= 1'b1;
    end else if (en_write && lane_last) begin
      loaded <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      shift_reg <= i_beat.data;
      last_q    <= i_beat.last;
    end else if (en_write) begin
      shift_reg <= shift_reg >> out_pkg::Y_BITS;  // next lane into slot 0
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn || state_w == W_IDLE) begin
      row_cnt <= '0;
      w_addr  <= '0;
    end else if (en_write) begin
      row_cnt <= lane_last ? '0 : row_cnt + 1'b1;
      w_addr  <= w_addr + 1'b1;  // b*ROWS + r
    end
  end

  // read side
  always_comb begin
    state_r_next = state_r;
    case (state_r)
      R_IDLE:      if (done_write[i_read]) state_r_next = R_DONE_FILL;
      R_DONE_FILL: state_r_next = R_READ;
      R_READ:      if (!df_was_high && i_done_firmware) state_r_next = R_WAIT;
      R_WAIT:      state_r_next = R_SWITCH;
      R_SWITCH:    state_r_next = R_IDLE;
      default:     state_r_next = R_IDLE;
    endcase
  end

  assign o_done_fill = state_r == R_DONE_FILL;
  assign r_addr      = i_rd_addr[ADDR_BITS-1:0];
  assign o_rd_data   = ram_dout[i_read];

  // a level left high from the previous frame must drop before it counts again
  always_ff @(posedge clk) begin
    if (!rstn) begin
      df_was_high <= 1'b0;
    end else if (!i_done_firmware) begin
      df_was_high <= 1'b0;
    end else if (state_r == R_READ) begin
      df_was_high <= 1'b1;
    end
  end

  // ping-pong bookkeeping
  always_ff @(posedge clk) begin
    if (!rstn) begin
      done_write <= 2'b00;
      done_read  <= 2'b11;  // both banks free
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (i_write == 1'(i)) begin
          if (state_w == W_IDLE && state_w_next == W_WRITE) done_write[i] <= 1'b0;
          else if (state_w == W_FILL)                       done_write[i] <= 1'b1;
        end
        if (i_read == 1'(i)) begin
          if (state_r == R_IDLE && state_r_next == R_DONE_FILL) done_read[i] <= 1'b0;
          else if (state_r == R_SWITCH)                         done_read[i] <= 1'b1;
        end
      end
    end
  end

  for (genvar i = 0; i < 2; i++) begin : g_bank
    assign ram_wen[i]  = (i_write == 1'(i)) && en_write;
    assign ram_addr[i] = (i_write == 1'(i) && state_w == W_WRITE) ? w_addr : r_addr;

    ram_output #(
      .DEPTH   (DEPTH),
      .LATENCY (RAM_LATENCY)
    ) u_ram (
      .clk    (clk),
      .i_wen  (ram_wen[i]),
      .i_addr (ram_addr[i]),
      .i_din  (shift_reg[0]),
      .o_dout (ram_dout[i])
    );
  end

endmodule

`default_nettype wire

//--- source/ram_output.sv
`timescale 1ns/100ps
`default_nettype none

module ram_output #(
  parameter int DEPTH   = 64,
  parameter int LATENCY = 2
) (
  input  logic                     clk,
  input  logic                     i_wen,
  input  logic [$clog2(DEPTH)-1:0] i_addr,
  input  out_pkg::y_t              i_din,
  output out_pkg::y_t              o_dout
);

  out_pkg::y_t mem [DEPTH];
  out_pkg::y_t rd_pipe [LATENCY];  // read data stages

  always_ff @(posedge clk) begin
    if (i_wen) mem[i_addr] <= i_din;
    rd_pipe[0] <= mem[i_addr];
    for (int i = 1; i < LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign o_dout = rd_pipe[LATENCY-1];

endmodule

`default_nettype wire

//--- source/requantizer.sv
`timescale 1ns/100ps
`default_nettype none

module requantizer #(
  parameter int ROWS = 4
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    i_acc_valid,
  input  out_pkg::acc_t [ROWS-1:0] i_acc_data,
  input  logic                    i_acc_last,
  output logic                    o_acc_ready,
  input  out_pkg::shift_t         i_shift,
  beat_if.src                     o_beat
);

  localparam out_pkg::acc_t Y_MAX = (2 ** (out_pkg::Y_BITS - 1)) - 1;
  localparam out_pkg::acc_t Y_MIN = -(2 ** (out_pkg::Y_BITS - 1));

  logic run;  // low through reset and one cycle after

  // arithmetic shift, then clip to the signed element range
  function automatic out_pkg::y_t requant(input out_pkg::acc_t a, input out_pkg::shift_t s);
    out_pkg::acc_t sh;
    sh = a >>> s;
    if (sh > Y_MAX) return out_pkg::y_t'(Y_MAX);
    if (sh < Y_MIN) return out_pkg::y_t'(Y_MIN);
    return out_pkg::y_t'(sh);
  endfunction

  // take a new item when empty or when the held one leaves
  assign o_acc_ready = run && (!o_beat.valid || o_beat.ready);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      run          <= 1'b0;
      o_beat.valid <= 1'b0;
    end else begin
      run <= 1'b1;
      if (o_acc_ready) o_beat.valid <= i_acc_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (o_acc_ready && i_acc_valid) begin
      for (int r = 0; r < ROWS; r++) begin
        o_beat.data[r] <= requant(i_acc_data[r], i_shift);
      end
      o_beat.last <= i_acc_last;  // travels with its beat
    end
  end

endmodule

`default_nettype wire

//--- source/beat_if.sv
`timescale 1ns/100ps
`default_nettype none

interface beat_if #(
  parameter int ROWS = 4
) ();

  logic                   valid;
  logic                   ready;
  logic                   last;   // final beat of a frame
  out_pkg::y_t [ROWS-1:0] data;

  // producer side
  modport src (output valid, last, data, input ready);

  // consumer side
  modport dst (input valid, last, data, output ready);

endinterface

`default_nettype wire

//--- source/out_pkg.sv
`default_nettype none

package out_pkg;

  localparam int Y_BITS     = 8;
  localparam int ACC_BITS   = 32;
  localparam int SHIFT_BITS = 5;

  typedef logic signed [Y_BITS-1:0]   y_t;    // requantized output element
  typedef logic signed [ACC_BITS-1:0] acc_t;  // one accumulator lane
  typedef logic [SHIFT_BITS-1:0]      shift_t;
  typedef logic [11:0]                apb_addr_t;
  typedef logic [31:0]                apb_data_t;

  // register map
  localparam apb_addr_t REG_STATUS  = 12'h000;  // bit0 frame_ready
  localparam apb_addr_t REG_CONTROL = 12'h004;  // bit0 done_firmware
  localparam apb_addr_t REG_SHIFT   = 12'h008;

  // data window, word index sits in paddr[10:2]
  localparam int WIN_BIT = 11;
  localparam int WIN_MSB = 10;
  localparam int WIN_LSB = 2;
  typedef logic [WIN_MSB-WIN_LSB:0] win_idx_t;

endpackage

`default_nettype wire
